/* filelist.f */
+incdir+bench
hdl/mul_pkg.sv
hdl/apb_regs_pkg.sv
hdl/array_mul.sv
hdl/cla_adder.sv
hdl/mul16_core.sv
hdl/apb_mul_regs.sv
hdl/mul16_apb_top.sv
bench/tb_mul16.sv

/* Bender.yml */
package:
  name: mul16_apb

sources:
  - target: any(synthesis, simulation)
    files:
      - hdl/mul_pkg.sv
      - hdl/apb_regs_pkg.sv
      - hdl/array_mul.sv
      - hdl/cla_adder.sv
      - hdl/mul16_core.sv
      - hdl/apb_mul_regs.sv
      - hdl/mul16_apb_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/tb_mul16.sv

/* bench/apb_bfm_tasks.svh */
// APB3 master tasks for the multiplier testbench, included inside the testbench module

// Completion is sampled on the rising edge where psel, penable and pready are high
task automatic wait_ready(input  logic [APB_ADDR_WIDTH-1:0] addr,
                          output int                        waits);
  waits = 0;
  @(posedge clk);
  while (!pready && waits < READY_LIMIT) begin
    waits++;
    @(posedge clk);
  end
  if (!pready) begin
    $display("Transfer to offset 0x%02h got no pready within %0d cycles", addr, READY_LIMIT);
    err_count++;
  end
endtask

task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] addr,
                         input logic [APB_DATA_WIDTH-1:0] data,
                         input logic                      exp_err);
  int waits;
  @(negedge clk);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = 1'b1;
  paddr   = addr;
  pwdata  = data;
  @(negedge clk);
  penable = 1'b1;
  wait_ready(addr, waits);
  // Writes never stall
  check_value("pready wait cycles", waits, 32'h0);
  check_value("pslverr", pslverr, exp_err);
  @(negedge clk);
  psel    = 1'b0;
  penable = 1'b0;
endtask

task automatic apb_read(input  logic [APB_ADDR_WIDTH-1:0] addr,
                        output logic [APB_DATA_WIDTH-1:0] data,
                        input  logic                      exp_err);
  int waits;
  @(negedge clk);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = 1'b0;
  paddr   = addr;
  @(negedge clk);
  penable = 1'b1;
  wait_ready(addr, waits);
  data = prdata;
  // Only a result read may stall
  if (addr != REG_RESULT) begin
    check_value("pready wait cycles", waits, 32'h0);
  end
  check_value("pslverr", pslverr, exp_err);
  @(negedge clk);
  psel    = 1'b0;
  penable = 1'b0;
endtask

/* bench/tb_mul16.sv */
// Self-checking testbench for the APB multiplier; run as top module tb_mul16
`timescale 1ns/100ps

module tb_mul16
  import apb_regs_pkg::*;
();

  localparam int RESET_CYCLES = 16;
  localparam int NUM_RANDOM   = 200;
  // Reset, five corners, random pairs, then status, bad access and plain write
  localparam int NUM_TESTS      = 1 + 5 + NUM_RANDOM + 3;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 20 + RESET_CYCLES;
  localparam int READY_LIMIT    = 16;
  localparam logic [APB_ADDR_WIDTH-1:0] BAD_ADDR = 5'h14;

  logic                      clk;
  logic                      arst_n;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [APB_ADDR_WIDTH-1:0] paddr;
  logic [APB_DATA_WIDTH-1:0] pwdata;
  logic [APB_DATA_WIDTH-1:0] prdata;
  logic                      pready;
  logic                      pslverr;

  int     err_count   = 0;
  int     err_mark    = 0;
  int     test_count  = 0;
  int     test_fail   = 0;
  int     cycle_count = 0;
  integer seed        = 32'hd6f7efae;

  mul16_apb_top u_dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  // Exact unsigned product of two 16-bit values
  function automatic logic [31:0] ref_mul(input logic [15:0] a, input logic [15:0] b);
    return 32'(a) * 32'(b);
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      err_count++;
    end
  endtask

  `include "apb_bfm_tasks.svh"

  task automatic end_test(input string name);
    test_count++;
    if (err_count == err_mark) begin
      $display("test %0d %s: ok", test_count, name);
    end else begin
      test_fail++;
      $display("test %0d %s: %0d errors", test_count, name, err_count - err_mark);
    end
    err_mark = err_count;
  endtask

  task automatic run_product(input logic [15:0] a, input logic [15:0] b);
    logic [31:0] rdata;
    apb_write(REG_OP_A, {16'h0, a}, 1'b0);
    apb_write(REG_OP_B, {16'h0, b}, 1'b0);
    apb_write(REG_CTRL, 32'h1 << CTRL_START_BIT, 1'b0);
    apb_read(REG_RESULT, rdata, 1'b0);
    check_value("prdata", rdata, ref_mul(a, b));
  endtask

  initial begin
    logic [31:0] rdata;
    logic [15:0] a;
    logic [15:0] b;
    logic [31:0] last_product;
    arst_n  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;

    apb_read(REG_STATUS, rdata, 1'b0);
    check_value("status", rdata, 32'h0);
    apb_read(REG_RESULT, rdata, 1'b0);
    check_value("result", rdata, 32'h0);
    end_test("reset values");

    run_product(16'h0000, 16'h0000);
    run_product(16'hFFFF, 16'hFFFF);
    run_product(16'hFFFF, 16'h0001);
    run_product(16'h00FF, 16'hFF00);
    run_product(16'h8000, 16'h0002);
    end_test("corner products");

    for (int i = 0; i < NUM_RANDOM; i++) begin
      a = $random(seed);
      b = $random(seed);
      run_product(a, b);
    end
    end_test("random products");

    a = 16'hBEEF;
    b = 16'h1357;
    apb_write(REG_OP_A, {16'h0, a}, 1'b0);
    apb_write(REG_OP_B, {16'h0, b}, 1'b0);
    apb_write(REG_CTRL, 32'h1 << CTRL_START_BIT, 1'b0);
    apb_read(REG_STATUS, rdata, 1'b0);
    check_value("status busy or done", rdata[STATUS_BUSY_BIT] | rdata[STATUS_DONE_BIT], 1'b1);
    // New operand and a second start, then a result read that has to stall
    a = 16'h7A31;
    last_product = ref_mul(a, b);
    apb_write(REG_OP_A, {16'h0, a}, 1'b0);
    apb_write(REG_CTRL, 32'h1 << CTRL_START_BIT, 1'b0);
    apb_read(REG_RESULT, rdata, 1'b0);
    check_value("result", rdata, last_product);
    apb_read(REG_STATUS, rdata, 1'b0);
    check_value("status", rdata, 32'h1 << STATUS_DONE_BIT);
    end_test("status bits");

    apb_write(REG_OP_A, 32'h0000_1234, 1'b0);
    apb_write(BAD_ADDR, 32'h0000_5A5A, 1'b1);
    apb_read(BAD_ADDR, rdata, 1'b1);
    apb_read(REG_OP_A, rdata, 1'b0);
    check_value("op_a", rdata, 32'h0000_1234);
    end_test("bad access");

    apb_write(REG_CTRL, 32'h0, 1'b0);
    apb_read(REG_STATUS, rdata, 1'b0);
    check_value("status", rdata, 32'h1 << STATUS_DONE_BIT);
    apb_read(REG_RESULT, rdata, 1'b0);
    check_value("result", rdata, last_product);
    end_test("plain control write");

    $display("%0d tests, %0d failed, %0d errors", test_count, test_fail, err_count);
    if (err_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* hdl/mul16_apb_top.sv */
// Top level of the APB-attached 16x16 multiplier; joins the register block to the core
`timescale 1ns/100ps

module mul16_apb_top
  import mul_pkg::*;
  import apb_regs_pkg::*;
#(
  parameter int DATA_WIDTH = OPERAND_WIDTH
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [APB_ADDR_WIDTH-1:0] paddr,
  input  logic [APB_DATA_WIDTH-1:0] pwdata,
  output logic [APB_DATA_WIDTH-1:0] prdata,
  output logic                      pready,
  output logic                      pslverr
);

  logic [DATA_WIDTH-1:0] operand_a;
  logic [DATA_WIDTH-1:0] operand_b;
  logic                  start;
  logic                  done;
  product_t              product;

  apb_mul_regs #(.DATA_WIDTH(DATA_WIDTH)) u_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .start     (start),
    .product   (product),
    .done      (done)
  );

  mul16_core #(.DATA_WIDTH(DATA_WIDTH)) u_core (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .product   (product),
    .done      (done)
  );

endmodule

/* hdl/apb_mul_regs.sv */
// APB slave holding the operand, control, status and result registers of the multiplier
`timescale 1ns/100ps

module apb_mul_regs
  import mul_pkg::*;
  import apb_regs_pkg::*;
#(
  parameter int DATA_WIDTH = OPERAND_WIDTH
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [APB_ADDR_WIDTH-1:0] paddr,
  input  logic [APB_DATA_WIDTH-1:0] pwdata,
  output logic [APB_DATA_WIDTH-1:0] prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic [DATA_WIDTH-1:0]     operand_a,
  output logic [DATA_WIDTH-1:0]     operand_b,
  output logic                      start,
  input  product_t                  product,
  input  logic                      done
);

  rd_state_e                 state_q, state_d;
  logic                      access, wr_en, start_wr, rd_result;
  logic                      busy, done_flag, addr_ok;
  logic [1:0]                pend_cnt;
  product_t                  result_q;
  logic [APB_DATA_WIDTH-1:0] rdata;

  assign access    = psel & penable;
  assign wr_en     = access & pwrite & pready;
  assign rd_result = access & ~pwrite & (paddr == REG_RESULT);
  assign start_wr  = wr_en & (paddr == REG_CTRL) & pwdata[CTRL_START_BIT];

  // Up to two products can be in flight
  assign busy = (pend_cnt != 2'd0);

  // Stall a result read until every pending product has landed
  always_comb begin
    state_d = state_q;
    case (state_q)
      RD_IDLE: if (rd_result && busy) state_d = RD_WAIT;
      RD_WAIT: if (!busy || !access) state_d = RD_IDLE;
      default: state_d = RD_IDLE;
    endcase
  end

  assign pready  = access & ((state_q == RD_WAIT) ? ~busy : ~(rd_result & busy));
  assign pslverr = access & ~addr_ok;
  assign prdata  = rdata;

  always_comb begin
    rdata   = '0;
    addr_ok = 1'b1;
    case (paddr)
      REG_OP_A:   rdata[DATA_WIDTH-1:0] = operand_a;
      REG_OP_B:   rdata[DATA_WIDTH-1:0] = operand_b;
      REG_CTRL:   rdata = '0;
      REG_STATUS: begin
        rdata[STATUS_BUSY_BIT] = busy;
        rdata[STATUS_DONE_BIT] = done_flag;
      end
      REG_RESULT: rdata = result_q;
      default:    addr_ok = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= RD_IDLE;
      operand_a <= '0;
      operand_b <= '0;
      result_q  <= '0;
      start     <= 1'b0;
      done_flag <= 1'b0;
      pend_cnt  <= 2'd0;
    end else begin
      state_q <= state_d;
      start   <= start_wr;
      if (wr_en && paddr == REG_OP_A) operand_a <= pwdata[DATA_WIDTH-1:0];
      if (wr_en && paddr == REG_OP_B) operand_b <= pwdata[DATA_WIDTH-1:0];
      if (done) result_q <= product;
      // A new start hides the done of an older product
      if (start_wr) begin
        done_flag <= 1'b0;
      end else if (done) begin
        done_flag <= 1'b1;
      end
      if (start_wr && !done) begin
        pend_cnt <= pend_cnt + 2'd1;
      end else if (!start_wr && done) begin
        pend_cnt <= pend_cnt - 2'd1;
      end
    end
  end

endmodule

/* hdl/mul16_core.sv */
// Two-stage multiplier core: half-width partial products, then a lookahead sum
`timescale 1ns/100ps

module mul16_core
  import mul_pkg::*;
#(
  parameter int DATA_WIDTH = OPERAND_WIDTH
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  start,
  input  logic [DATA_WIDTH-1:0] operand_a,
  input  logic [DATA_WIDTH-1:0] operand_b,
  output product_t              product,
  output logic                  done
);

  localparam int HALF = DATA_WIDTH / 2;
  localparam int PW   = 2 * DATA_WIDTH;

  logic [DATA_WIDTH-1:0] ll, lh, hl, hh;
  logic [DATA_WIDTH-1:0] ll_q, lh_q, hl_q, hh_q;
  logic                  vld_q;
  logic [PW-1:0]         llhh, lh_sh, hl_sh, mid_sum, total, product_q;

  // Quadrant products
  array_mul #(.WIDTH(HALF)) u_ll (.a(operand_a[HALF-1:0]), .b(operand_b[HALF-1:0]), .p(ll));
  array_mul #(.WIDTH(HALF)) u_lh (.a(operand_a[HALF-1:0]), .b(operand_b[DATA_WIDTH-1:HALF]), .p(lh));
  array_mul #(.WIDTH(HALF)) u_hl (.a(operand_a[DATA_WIDTH-1:HALF]), .b(operand_b[HALF-1:0]), .p(hl));
  array_mul #(.WIDTH(HALF)) u_hh (.a(operand_a[DATA_WIDTH-1:HALF]),
                                  .b(operand_b[DATA_WIDTH-1:HALF]), .p(hh));

  always_ff @(posedge clk) begin
    ll_q <= ll;
    lh_q <= lh;
    hl_q <= hl;
    hh_q <= hh;
  end

  // Middle products sit half a width up
  assign llhh  = {hh_q, ll_q};
  assign lh_sh = {{HALF{1'b0}}, lh_q, {HALF{1'b0}}};
  assign hl_sh = {{HALF{1'b0}}, hl_q, {HALF{1'b0}}};

  cla_adder #(.WIDTH(PW)) u_sum_mid (.a(llhh), .b(lh_sh), .sum(mid_sum));
  cla_adder #(.WIDTH(PW)) u_sum_out (.a(mid_sum), .b(hl_sh), .sum(total));

  always_ff @(posedge clk) begin
    product_q <= total;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= 1'b0;
      done  <= 1'b0;
    end else begin
      vld_q <= start;
      done  <= vld_q;
    end
  end

  assign product = product_q;

endmodule

/* hdl/cla_adder.sv */
// Two-level carry-lookahead adder with fixed-size groups, carry in tied low
`timescale 1ns/100ps

module cla_adder
  import mul_pkg::*;
#(
  parameter int WIDTH = 2 * OPERAND_WIDTH
) (
  input  logic [WIDTH-1:0] a,
  input  logic [WIDTH-1:0] b,
  output logic [WIDTH-1:0] sum
);

  localparam int GROUPS = WIDTH / CLA_GROUP;

  logic [WIDTH-1:0]  p, g, c;
  logic [GROUPS-1:0] gp, gg, gc;

  assign p = a ^ b;
  assign g = a & b;

  // First level, per-group propagate and generate
  always_comb begin
    for (int k = 0; k < GROUPS; k++) begin
      gp[k] = &p[k*CLA_GROUP +: CLA_GROUP];
      gg[k] = 1'b0;
      for (int m = 0; m < CLA_GROUP; m++) begin
        gg[k] = g[k*CLA_GROUP+m] | (p[k*CLA_GROUP+m] & gg[k]);
      end
    end
  end

  // Second level, group carries as a sum of products
  always_comb begin
    logic term;
    gc[0] = 1'b0;
    for (int k = 1; k < GROUPS; k++) begin
      gc[k] = 1'b0;
      for (int j = 0; j < k; j++) begin
        term = gg[j];
        for (int m = j + 1; m < k; m++) begin
          term = term & gp[m];
        end
        gc[k] = gc[k] | term;
      end
    end
  end

  // Carries inside each group
  always_comb begin
    for (int k = 0; k < GROUPS; k++) begin
      c[k*CLA_GROUP] = gc[k];
      for (int m = 1; m < CLA_GROUP; m++) begin
        c[k*CLA_GROUP+m] = g[k*CLA_GROUP+m-1] | (p[k*CLA_GROUP+m-1] & c[k*CLA_GROUP+m-1]);
      end
    end
  end

  assign sum = p ^ c;

endmodule

/* hdl/array_mul.sv */
// Unsigned array multiplier, one adder row per multiplier bit plus a closing ripple row
`timescale 1ns/100ps

module array_mul
  import mul_pkg::*;
#(
  parameter int WIDTH = HALF_WIDTH_DEFAULT
) (
  input  logic [WIDTH-1:0]   a,
  input  logic [WIDTH-1:0]   b,
  output logic [2*WIDTH-1:0] p
);

  // Row sums and carries, row i adds a[i] times b
  wire [WIDTH-1:0] s [WIDTH];
  wire [WIDTH-2:0] c [1:WIDTH-1];
  wire [WIDTH-1:1] rc;

  genvar i, j;

  for (j = 0; j < WIDTH; j++) begin : g_row0
    assign s[0][j] = a[0] & b[j];
  end

  for (i = 1; i < WIDTH; i++) begin : g_rows
    for (j = 0; j < WIDTH - 1; j++) begin : g_cells
      wire pp;
      assign pp = a[i] & b[j];
      if (i == 1) begin : g_ha
        assign s[i][j] = s[i-1][j+1] ^ pp;
        assign c[i][j] = s[i-1][j+1] & pp;
      end else begin : g_fa
        assign s[i][j] = s[i-1][j+1] ^ c[i-1][j] ^ pp;
        assign c[i][j] = (s[i-1][j+1] & c[i-1][j]) | (pp & (s[i-1][j+1] ^ c[i-1][j]));
      end
    end
    assign s[i][WIDTH-1] = a[i] & b[WIDTH-1];
  end

  // Low half falls out of the rows
  for (i = 0; i < WIDTH; i++) begin : g_low
    assign p[i] = s[i][0];
  end

  // Closing ripple row for the upper half
  for (j = 0; j < WIDTH - 1; j++) begin : g_ripple
    if (j == 0) begin : g_ha
      assign p[WIDTH] = s[WIDTH-1][1] ^ c[WIDTH-1][0];
      assign rc[1]    = s[WIDTH-1][1] & c[WIDTH-1][0];
    end else begin : g_fa
      assign p[WIDTH+j] = s[WIDTH-1][j+1] ^ c[WIDTH-1][j] ^ rc[j];
      assign rc[j+1]    = (s[WIDTH-1][j+1] & c[WIDTH-1][j]) |
                          (rc[j] & (s[WIDTH-1][j+1] ^ c[WIDTH-1][j]));
    end
  end

  assign p[2*WIDTH-1] = rc[WIDTH-1];

endmodule

/* hdl/apb_regs_pkg.sv */
// APB register map and slave state encoding, imported by the register block and the top
package apb_regs_pkg;

  localparam int APB_ADDR_WIDTH = 5;
  localparam int APB_DATA_WIDTH = 32;

  // Byte offsets of the registers
  typedef enum logic [APB_ADDR_WIDTH-1:0] {
    REG_OP_A   = 5'h00,
    REG_OP_B   = 5'h04,
    REG_CTRL   = 5'h08,
    REG_STATUS = 5'h0C,
    REG_RESULT = 5'h10
  } reg_addr_e;

  // Control word fields
  localparam int CTRL_START_BIT = 0;

  // Status word fields
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;

  // Result read stall
  typedef enum logic {
    RD_IDLE,
    RD_WAIT
  } rd_state_e;

endpackage

/* hdl/mul_pkg.sv */
// Datapath widths and adder grouping shared by the multiplier core and its APB wrapper
package mul_pkg;

  // Width of each unsigned operand
  localparam int OPERAND_WIDTH = 16;

  // Width of one partial-product multiplier
  localparam int HALF_WIDTH_DEFAULT = 8;

  // Bits per carry-lookahead group
  localparam int CLA_GROUP = 4;

  // Full-width product
  typedef logic [2*OPERAND_WIDTH-1:0] product_t;

endpackage
